//--- include/conv_accel_cfg.svh
`ifndef CONV_ACCEL_CFG_SVH
`define CONV_ACCEL_CFG_SVH

// Frame limits and datapath widths
`define CONV_MAX_DIM        32
`define CONV_DIM_W          6
`define CONV_PIX_ADDR_W     10
`define CONV_PIXEL_W        8
`define CONV_WEIGHT_W       8
`define CONV_TAPS           9
`define CONV_ACC_W          21      // Nine signed 17-bit products
`define CONV_BIAS_W         16

// Address decode
`define CONV_REG_IDX_LSB    2
`define CONV_REG_IDX_W      4
`define CONV_PIX_ADDR_LSB   6       // Pixel address of IMAGE writes
`define CONV_RESET_DIM      8

// Register map
`define CONV_REG_SIZE       0
`define CONV_REG_LAYER_CFG  1
`define CONV_REG_BIAS       2
`define CONV_REG_WEIGHT_LO  3
`define CONV_REG_WEIGHT_HI  4
`define CONV_REG_WEIGHT_C   5
`define CONV_REG_IMAGE      6
`define CONV_REG_START      7
`define CONV_REG_DONE       8

`endif

//--- source/conv_pkg.sv
`include "conv_accel_cfg.svh"

package conv_pkg;

	// ------------------------------
	// Bus side
	// ------------------------------
	typedef logic [31:0] bus_word_t;
	typedef logic [`CONV_REG_IDX_W-1:0] reg_idx_t;

	// ------------------------------
	// Frame and image store
	// ------------------------------
	typedef logic [`CONV_DIM_W-1:0] dim_t;
	typedef logic [`CONV_PIX_ADDR_W-1:0] pix_addr_t;
	typedef logic [`CONV_PIXEL_W-1:0] pixel_t;

	// ------------------------------
	// Kernel and arithmetic
	// ------------------------------
	typedef logic signed [`CONV_WEIGHT_W-1:0] weight_t;

	// Tap 0 upper left, tap 8 lower right, raster order
	typedef weight_t [`CONV_TAPS-1:0] weight_set_t;
	typedef pixel_t [`CONV_TAPS-1:0] window_t;

	typedef logic signed [`CONV_ACC_W-1:0] acc_t;
	typedef logic signed [`CONV_BIAS_W-1:0] bias_t;
	typedef logic [2:0] shift_t;

	// Unsigned for ReLU, two's complement for linear
	typedef logic [`CONV_PIXEL_W-1:0] out_pixel_t;

endpackage

//--- source/cfg_if.sv
`timescale 1ns/1ps

interface cfg_if import conv_pkg::*; ();

	dim_t        width;
	dim_t        height;
	logic        act_linear;     // 0 ReLU, 1 linear
	shift_t      act_shift;
	bias_t       bias;
	weight_set_t weights;
	logic        start;          // One-cycle pulse
	logic        done_clr;       // One-cycle pulse on DONE write
	logic        busy;
	logic        done;

	modport decode (
		output width, height, act_linear, act_shift, bias, weights, start, done_clr,
		input  busy, done
	);

	modport execute (input width, height, weights, start, output busy);

	modport result (
		input  width, height, bias, act_linear, act_shift, start, done_clr,
		output done
	);

endinterface

//--- source/bus_regs.sv
`timescale 1ns/1ps
`include "conv_accel_cfg.svh"

module bus_regs import conv_pkg::*; (
	input  logic      clk,
	input  logic      rstn,
	input  logic      hsel_i,
	input  logic      hready_i,
	input  logic      hwrite_i,
	input  logic [1:0] htrans_i,
	input  bus_word_t haddr_i,
	input  bus_word_t hwdata_i,
	output bus_word_t hrdata_o,
	output logic      pix_we_o,
	output pix_addr_t pix_addr_o,
	output pixel_t    pix_data_o,
	cfg_if.decode     cfg
);

	reg_idx_t  sel_q;            // Register index of the data phase
	logic      ld_q;             // Write pending in the data phase
	pix_addr_t pix_addr_q;
	logic      addr_accept;

	// ------------------------------
	// Address phase
	// ------------------------------
	assign addr_accept = hsel_i && hready_i && htrans_i[1];   // NONSEQ or SEQ

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			sel_q      <= '0;
			ld_q       <= 1'b0;
			pix_addr_q <= '0;
		end else if (addr_accept) begin
			sel_q      <= haddr_i[`CONV_REG_IDX_LSB +: `CONV_REG_IDX_W];
			ld_q       <= hwrite_i;
			pix_addr_q <= haddr_i[`CONV_PIX_ADDR_LSB +: `CONV_PIX_ADDR_W];
		end else begin
			ld_q <= 1'b0;
		end
	end

	// ------------------------------
	// Data phase
	// ------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			cfg.width      <= dim_t'(`CONV_RESET_DIM);
			cfg.height     <= dim_t'(`CONV_RESET_DIM);
			cfg.act_linear <= 1'b0;
			cfg.act_shift  <= '0;
			cfg.bias       <= '0;
			cfg.weights    <= '0;
			cfg.start      <= 1'b0;
			cfg.done_clr   <= 1'b0;
		end else begin
			cfg.start    <= 1'b0;
			cfg.done_clr <= 1'b0;
			if (ld_q) begin
				case (sel_q)
					`CONV_REG_SIZE: begin
						cfg.width  <= hwdata_i[5:0];
						cfg.height <= hwdata_i[21:16];
					end
					`CONV_REG_LAYER_CFG: begin
						cfg.act_linear <= hwdata_i[0];
						cfg.act_shift  <= hwdata_i[6:4];
					end
					`CONV_REG_BIAS:      cfg.bias <= hwdata_i[15:0];
					`CONV_REG_WEIGHT_LO: cfg.weights[3:0] <= hwdata_i;
					`CONV_REG_WEIGHT_HI: cfg.weights[7:4] <= hwdata_i;
					`CONV_REG_WEIGHT_C:  cfg.weights[8] <= hwdata_i[7:0];
					`CONV_REG_START:     cfg.start <= hwdata_i[0] && !cfg.busy;
					`CONV_REG_DONE:      cfg.done_clr <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	// Image writes go straight to the pixel store
	assign pix_we_o   = ld_q && (sel_q == `CONV_REG_IMAGE);
	assign pix_addr_o = pix_addr_q;
	assign pix_data_o = hwdata_i[7:0];

	// Read mux, unused bits zero
	always_comb begin
		case (sel_q)
			`CONV_REG_SIZE:      hrdata_o = {10'd0, cfg.height, 10'd0, cfg.width};
			`CONV_REG_LAYER_CFG: hrdata_o = {25'd0, cfg.act_shift, 3'd0, cfg.act_linear};
			`CONV_REG_BIAS:      hrdata_o = {16'd0, cfg.bias};
			`CONV_REG_WEIGHT_LO: hrdata_o = cfg.weights[3:0];
			`CONV_REG_WEIGHT_HI: hrdata_o = cfg.weights[7:4];
			`CONV_REG_WEIGHT_C:  hrdata_o = {24'd0, cfg.weights[8]};
			`CONV_REG_START:     hrdata_o = {31'd0, cfg.busy};
			`CONV_REG_DONE:      hrdata_o = {31'd0, cfg.done};
			default:             hrdata_o = '0;
		endcase
	end

endmodule

//--- source/window_fetch.sv
`timescale 1ns/1ps
`include "conv_accel_cfg.svh"

module window_fetch import conv_pkg::*; (
	input  logic      clk,
	input  logic      rstn,
	input  logic      pix_we_i,
	input  pix_addr_t pix_addr_i,
	input  pixel_t    pix_data_i,
	cfg_if.execute    cfg,
	output logic      win_valid_o,
	output window_t   win_o
);

	localparam int MEM_DEPTH = `CONV_MAX_DIM * `CONV_MAX_DIM;

	pixel_t     img_mem [MEM_DEPTH];
	dim_t       row;
	dim_t       col;
	logic       first_row;
	logic       last_row;
	logic       first_col;
	logic       last_col;
	logic [2:0] row_pad;         // Per window row, 1 means outside the frame
	logic [2:0] col_pad;
	pix_addr_t  center_addr;
	pix_addr_t  row_base [3];
	window_t    win_next;

	// Image store, written by the host only
	always_ff @(posedge clk) begin
		if (pix_we_i) begin
			img_mem[pix_addr_i] <= pix_data_i;
		end
	end

	// ------------------------------
	// Raster scanner
	// ------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			cfg.busy <= 1'b0;
			row      <= '0;
			col      <= '0;
		end else if (!cfg.busy) begin
			if (cfg.start) begin
				cfg.busy <= 1'b1;
				row      <= '0;
				col      <= '0;
			end
		end else if (last_col) begin
			col <= '0;
			if (last_row) begin
				cfg.busy <= 1'b0;                // Frame scanned
			end else begin
				row <= row + 1'b1;
			end
		end else begin
			col <= col + 1'b1;
		end
	end

	// Boundary flags
	assign first_row = (row == '0);
	assign last_row  = (row == cfg.height - 1'b1);
	assign first_col = (col == '0);
	assign last_col  = (col == cfg.width - 1'b1);
	assign row_pad   = {last_row, 1'b0, first_row};
	assign col_pad   = {last_col, 1'b0, first_col};

	assign center_addr = pix_addr_t'(row) * pix_addr_t'(cfg.width) + pix_addr_t'(col);
	assign row_base[0] = center_addr - pix_addr_t'(cfg.width);
	assign row_base[1] = center_addr;
	assign row_base[2] = center_addr + pix_addr_t'(cfg.width);

	// Gather the nine neighbors, zero outside the frame
	always_comb begin
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				if (row_pad[r] || col_pad[c]) begin
					win_next[r*3+c] = '0;
				end else begin
					win_next[r*3+c] = img_mem[row_base[r] + pix_addr_t'(c) - pix_addr_t'(1)];
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			win_valid_o <= 1'b0;
		end else begin
			win_valid_o <= cfg.busy;
		end
	end

	always_ff @(posedge clk) begin
		if (cfg.busy) begin
			win_o <= win_next;
		end
	end

endmodule

//--- source/mac_array.sv
`timescale 1ns/1ps
`include "conv_accel_cfg.svh"

module mac_array import conv_pkg::*; (
	input  logic        clk,
	input  logic        rstn,
	input  logic        win_valid_i,
	input  window_t     win_i,
	input  weight_set_t weights_i,
	output logic        acc_valid_o,
	output acc_t        acc_o
);

	// Unsigned pixel with sign bit times signed weight
	typedef logic signed [2*`CONV_WEIGHT_W:0] prod_t;

	prod_t prod_q [`CONV_TAPS];
	logic  prod_valid_q;
	acc_t  sum_c;

	// ------------------------------
	// Stage one, products
	// ------------------------------
	always_ff @(posedge clk) begin
		if (win_valid_i) begin
			for (int t = 0; t < `CONV_TAPS; t++) begin
				prod_q[t] <= $signed({1'b0, win_i[t]}) * $signed(weights_i[t]);
			end
		end
	end

	// ------------------------------
	// Stage two, adder tree
	// ------------------------------
	always_comb begin
		sum_c = '0;
		for (int t = 0; t < `CONV_TAPS; t++) begin
			sum_c = sum_c + prod_q[t];
		end
	end

	always_ff @(posedge clk) begin
		if (prod_valid_q) begin
			acc_o <= sum_c;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			prod_valid_q <= 1'b0;
			acc_valid_o  <= 1'b0;
		end else begin
			prod_valid_q <= win_valid_i;
			acc_valid_o  <= prod_valid_q;   // Two cycles behind the window
		end
	end

endmodule

//--- source/act_quant.sv
`timescale 1ns/1ps
`include "conv_accel_cfg.svh"

module act_quant import conv_pkg::*; (
	input  logic       clk,
	input  logic       rstn,
	input  logic       acc_valid_i,
	input  acc_t       acc_i,
	cfg_if.result      cfg,
	output logic       pixel_valid_o,
	output out_pixel_t pixel_o,
	output logic       done_o
);

	logic signed [`CONV_ACC_W:0] biased;     // One bit of headroom for the bias
	logic signed [`CONV_ACC_W:0] shifted;
	out_pixel_t                  quant;
	logic [2*`CONV_DIM_W-1:0]    frame_px;
	logic [2*`CONV_DIM_W-1:0]    out_cnt;

	assign biased   = acc_i + cfg.bias;
	assign shifted  = biased >>> cfg.act_shift;
	assign frame_px = cfg.width * cfg.height;

	// Activation and saturation
	always_comb begin
		if (!cfg.act_linear) begin
			if (shifted < 0) quant = 8'h00;
			else if (shifted > 255) quant = 8'hff;
			else quant = shifted[7:0];
		end else begin
			if (shifted < -128) quant = 8'h80;
			else if (shifted > 127) quant = 8'h7f;
			else quant = shifted[7:0];
		end
	end

	always_ff @(posedge clk) begin
		if (acc_valid_i) begin
			pixel_o <= quant;
		end
	end

	// ------------------------------
	// Output count and done flag
	// ------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			pixel_valid_o <= 1'b0;
			out_cnt       <= '0;
			cfg.done      <= 1'b0;
		end else begin
			pixel_valid_o <= acc_valid_i;
			if (cfg.start) begin
				out_cnt  <= '0;
				cfg.done <= 1'b0;
			end else if (pixel_valid_o) begin
				if (out_cnt == frame_px - 1'b1) begin
					out_cnt  <= '0;
					cfg.done <= 1'b1;              // Last pixel of the frame
				end else begin
					out_cnt <= out_cnt + 1'b1;
				end
			end else if (cfg.done_clr) begin
				cfg.done <= 1'b0;
			end
		end
	end

	assign done_o = cfg.done;

endmodule

//--- source/conv_accel.sv
`timescale 1ns/1ps

module conv_accel import conv_pkg::*; (
	input  logic       clk,
	input  logic       rstn,
	// Register bus
	input  logic       hsel_i,
	input  logic       hready_i,
	input  logic [1:0] htrans_i,
	input  logic       hwrite_i,
	input  bus_word_t  haddr_i,
	input  bus_word_t  hwdata_i,
	output bus_word_t  hrdata_o,
	// Result stream
	output logic       pixel_valid_o,
	output out_pixel_t pixel_o,
	output logic       done_o
);

	logic      pix_we;
	pix_addr_t pix_addr;
	pixel_t    pix_data;
	logic      win_valid;
	window_t   win;
	logic      acc_valid;
	acc_t      acc;

	cfg_if cfg_bus ();

	// ------------------------------
	// Decode
	// ------------------------------
	bus_regs u_bus_regs (
		.clk        (clk),
		.rstn       (rstn),
		.hsel_i     (hsel_i),
		.hready_i   (hready_i),
		.hwrite_i   (hwrite_i),
		.htrans_i   (htrans_i),
		.haddr_i    (haddr_i),
		.hwdata_i   (hwdata_i),
		.hrdata_o   (hrdata_o),
		.pix_we_o   (pix_we),
		.pix_addr_o (pix_addr),
		.pix_data_o (pix_data),
		.cfg        (cfg_bus.decode)
	);

	// ------------------------------
	// Execute and result
	// ------------------------------
	window_fetch u_window_fetch (
		.clk         (clk),
		.rstn        (rstn),
		.pix_we_i    (pix_we),
		.pix_addr_i  (pix_addr),
		.pix_data_i  (pix_data),
		.cfg         (cfg_bus.execute),
		.win_valid_o (win_valid),
		.win_o       (win)
	);

	mac_array u_mac_array (
		.clk         (clk),
		.rstn        (rstn),
		.win_valid_i (win_valid),
		.win_i       (win),
		.weights_i   (cfg_bus.weights),
		.acc_valid_o (acc_valid),
		.acc_o       (acc)
	);

	act_quant u_act_quant (
		.clk           (clk),
		.rstn          (rstn),
		.acc_valid_i   (acc_valid),
		.acc_i         (acc),
		.cfg           (cfg_bus.result),
		.pixel_valid_o (pixel_valid_o),
		.pixel_o       (pixel_o),
		.done_o        (done_o)
	);

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS = 10
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

endmodule

//--- bench/tb_conv_accel.sv
`timescale 1ns/1ps
`include "conv_accel_cfg.svh"

module tb_conv_accel import conv_pkg::*; ();

	localparam int CLK_PERIOD      = 10;
	localparam int NUM_TESTS       = 5;
	localparam int FRAME_PIXELS    = 64 + 35 + 4 + 4;     // All frames of the run
	localparam int WATCHDOG_CYCLES = FRAME_PIXELS + 200 * NUM_TESTS;
	localparam int FIRST_PIX_LAT   = 5;                   // Cycles after the START data phase

	logic       clk;
	logic       rstn;
	logic       hsel_i;
	logic       hready_i;
	logic       hwrite_i;
	logic [1:0] htrans_i;
	bus_word_t  haddr_i;
	bus_word_t  hwdata_i;
	bus_word_t  hrdata_o;
	logic       pixel_valid_o;
	out_pixel_t pixel_o;
	logic       done_o;

	// Reference model state
	pixel_t     img [`CONV_MAX_DIM * `CONV_MAX_DIM];
	weight_t    wts [`CONV_TAPS];
	int         fr_w;
	int         fr_h;
	int         bias_v;
	int         shift_v;
	bit         lin_v;

	int         seed;
	out_pixel_t exp_q [$];
	int         pix_seen = 0;       // Owned by the compare process
	int         frame_first;
	int         clamp_lo;
	int         clamp_hi;
	time        start_time;
	time        last_wr_time;
	time        first_pix_time;
	time        last_pix_time;
	int         value_errors = 0;
	int         pixel_errors = 0;
	int         other_errors = 0;

	tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_tb_clock (.clk(clk));

	conv_accel u_conv_accel (
		.clk(clk), .rstn(rstn),
		.hsel_i(hsel_i), .hready_i(hready_i), .htrans_i(htrans_i), .hwrite_i(hwrite_i),
		.haddr_i(haddr_i), .hwdata_i(hwdata_i), .hrdata_o(hrdata_o),
		.pixel_valid_o(pixel_valid_o), .pixel_o(pixel_o), .done_o(done_o)
	);

	// ------------------------------
	// Reference model
	// ------------------------------
	function automatic out_pixel_t ref_pixel(input int r, input int c);
		int sum;
		int rr;
		int cc;
		sum = 0;
		for (int t = 0; t < `CONV_TAPS; t++) begin
			rr = r + t / 3 - 1;
			cc = c + t % 3 - 1;
			if (rr >= 0 && rr < fr_h && cc >= 0 && cc < fr_w) begin   // Zero padding
				sum += int'(img[rr * fr_w + cc]) * int'(wts[t]);
			end
		end
		sum = (sum + bias_v) >>> shift_v;
		if (!lin_v) begin
			if (sum < 0) sum = 0;
			if (sum > 255) sum = 255;
		end else begin
			if (sum < -128) sum = -128;
			if (sum > 127) sum = 127;
		end
		return out_pixel_t'(sum);
	endfunction

	function automatic bus_word_t reg_addr(input int idx);
		return bus_word_t'(idx) << `CONV_REG_IDX_LSB;
	endfunction

	// ------------------------------
	// Compare tasks
	// ------------------------------
	task automatic check_pixel(input string name, input out_pixel_t exp, input out_pixel_t act);
		if (act !== exp) begin
			pixel_errors++;
			$display("CHECK FAILED at %0t: %s expected 0x%02h, got 0x%02h", $time, name, exp, act);
		end
	endtask

	task automatic check_word(input string name, input bus_word_t exp, input bus_word_t act);
		if (act !== exp) begin
			value_errors++;
			$display("CHECK FAILED at %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			value_errors++;
			$display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	// ------------------------------
	// Bus transfers
	// ------------------------------
	task automatic bus_write(input bus_word_t addr, input bus_word_t data);
		hsel_i   = 1'b1;
		htrans_i = 2'b10;           // NONSEQ
		hwrite_i = 1'b1;
		haddr_i  = addr;
		@(posedge clk);
		#1;
		hsel_i   = 1'b0;
		htrans_i = 2'b00;
		hwrite_i = 1'b0;
		hwdata_i = data;
		@(posedge clk);
		last_wr_time = $time;       // Data phase edge
		#1;
	endtask

	task automatic bus_read(input bus_word_t addr, output bus_word_t data);
		hsel_i   = 1'b1;
		htrans_i = 2'b10;
		hwrite_i = 1'b0;
		haddr_i  = addr;
		@(posedge clk);
		#1;
		hsel_i   = 1'b0;
		htrans_i = 2'b00;
		data     = hrdata_o;
	endtask

	task automatic read_and_check(input bus_word_t addr, input bus_word_t exp,
		input string name);
		bus_word_t rd;
		bus_read(addr, rd);
		check_word(name, exp, rd);
	endtask

	// ------------------------------
	// Frame setup and run
	// ------------------------------
	task automatic randomize_data(input int n);
		for (int i = 0; i < n; i++) img[i] = pixel_t'($random(seed));
		for (int t = 0; t < `CONV_TAPS; t++) wts[t] = weight_t'($random(seed));
	endtask

	task automatic program_frame(input int w, input int h, input bit lin, input int shift,
		input int bias);
		fr_w    = w;
		fr_h    = h;
		lin_v   = lin;
		shift_v = shift;
		bias_v  = bias;
		bus_write(reg_addr(`CONV_REG_SIZE), (bus_word_t'(h) << 16) | bus_word_t'(w));
		bus_write(reg_addr(`CONV_REG_LAYER_CFG), (bus_word_t'(shift) << 4) | bus_word_t'(lin));
		bus_write(reg_addr(`CONV_REG_BIAS), bus_word_t'(bias) & 32'h0000_ffff);
		bus_write(reg_addr(`CONV_REG_WEIGHT_LO), {wts[3], wts[2], wts[1], wts[0]});
		bus_write(reg_addr(`CONV_REG_WEIGHT_HI), {wts[7], wts[6], wts[5], wts[4]});
		bus_write(reg_addr(`CONV_REG_WEIGHT_C), {24'd0, wts[8]});
		for (int i = 0; i < w * h; i++) begin
			bus_write((bus_word_t'(i) << `CONV_PIX_ADDR_LSB) | reg_addr(`CONV_REG_IMAGE),
				{24'd0, img[i]});
		end
	endtask

	// Runs one frame and checks busy, latency, count, done and DONE clear
	task automatic run_frame(input string name);
		int  wait_cnt;
		time done_time;
		frame_first = pix_seen;
		for (int r = 0; r < fr_h; r++) begin
			for (int c = 0; c < fr_w; c++) exp_q.push_back(ref_pixel(r, c));
		end
		bus_write(reg_addr(`CONV_REG_START), 32'h1);
		start_time = last_wr_time;
		read_and_check(reg_addr(`CONV_REG_START), 32'h1, "START busy");
		wait_cnt = 0;
		while (!done_o && wait_cnt < fr_w * fr_h + 50) begin
			@(posedge clk);
			#1;
			wait_cnt++;
		end
		done_time = $time;
		if (!done_o) begin
			other_errors++;
			$display("done_o never rose at the end of the %s frame", name);
		end else if (done_time - last_pix_time > CLK_PERIOD) begin
			other_errors++;
			$display("done_o rose late after the last pixel of the %s frame", name);
		end
		if (exp_q.size() != 0) begin
			other_errors++;
			$display("%0d expected pixels of the %s frame never arrived", exp_q.size(), name);
		end
		exp_q.delete();
		if (pix_seen - frame_first != fr_w * fr_h) begin
			other_errors++;
			$display("The %s frame gave %0d pixels instead of %0d", name,
				pix_seen - frame_first, fr_w * fr_h);
		end else if ((first_pix_time - start_time) / CLK_PERIOD != FIRST_PIX_LAT) begin
			other_errors++;
			$display("First pixel of the %s frame came %0d cycles after START, not %0d", name,
				(first_pix_time - start_time) / CLK_PERIOD, FIRST_PIX_LAT);
		end
		read_and_check(reg_addr(`CONV_REG_DONE), 32'h1, "DONE set");
		bus_write(reg_addr(`CONV_REG_DONE), 32'h0);
		read_and_check(reg_addr(`CONV_REG_DONE), 32'h0, "DONE cleared");
		check_flag("done_o", 1'b0, done_o);
	endtask

	// Compare process, pops one expected value per output pixel
	always @(negedge clk) begin
		if (rstn && pixel_valid_o) begin
			if (pix_seen == frame_first) first_pix_time = $time;
			last_pix_time = $time;
			if (exp_q.size() == 0) begin
				pixel_errors++;
				$display("Unexpected pixel 0x%02h at %0t with no value expected", pixel_o, $time);
			end else begin
				check_pixel("pixel_o", exp_q.pop_front(), pixel_o);
			end
			pix_seen++;
		end
	end

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		seed     = 60;
		rstn     = 1'b0;
		hsel_i   = 1'b0;
		hready_i = 1'b1;
		hwrite_i = 1'b0;
		htrans_i = 2'b00;
		haddr_i  = '0;
		hwdata_i = '0;
		repeat (5) @(posedge clk);
		#1;
		rstn = 1'b1;
		@(posedge clk);
		#1;

		// Reset values and register readback
		read_and_check(reg_addr(`CONV_REG_START), 32'h0, "START after reset");
		read_and_check(reg_addr(`CONV_REG_DONE), 32'h0, "DONE after reset");
		read_and_check(reg_addr(`CONV_REG_SIZE), 32'h0008_0008, "SIZE after reset");
		bus_write(reg_addr(`CONV_REG_SIZE), 32'hffe5_ffc7);
		read_and_check(reg_addr(`CONV_REG_SIZE), 32'hffe5_ffc7 & 32'h003f_003f, "SIZE");
		bus_write(reg_addr(`CONV_REG_LAYER_CFG), 32'hffff_ffab);
		read_and_check(reg_addr(`CONV_REG_LAYER_CFG), 32'hffff_ffab & 32'h71, "LAYER_CFG");
		bus_write(reg_addr(`CONV_REG_BIAS), 32'h5a5a_c3c3);
		read_and_check(reg_addr(`CONV_REG_BIAS), 32'h0000_c3c3, "BIAS");
		bus_write(reg_addr(`CONV_REG_WEIGHT_LO), 32'h8143_7fc2);
		read_and_check(reg_addr(`CONV_REG_WEIGHT_LO), 32'h8143_7fc2, "WEIGHT_LO");
		bus_write(reg_addr(`CONV_REG_WEIGHT_HI), 32'h0af0_33cc);
		read_and_check(reg_addr(`CONV_REG_WEIGHT_HI), 32'h0af0_33cc, "WEIGHT_HI");
		bus_write(reg_addr(`CONV_REG_WEIGHT_C), 32'hdead_be9f);
		read_and_check(reg_addr(`CONV_REG_WEIGHT_C), 32'h0000_009f, "WEIGHT_C");
		read_and_check(reg_addr(`CONV_REG_IMAGE), 32'h0, "IMAGE");
		read_and_check(reg_addr(12), 32'h0, "unmapped index");

		// ReLU 8x8 with random shift and bias
		randomize_data(64);
		program_frame(8, 8, 1'b0, $random(seed) & 7, $random(seed) % 4096);
		run_frame("ReLU 8x8");

		// Linear 7x5, strong center tap so both clamps are reached
		randomize_data(35);
		for (int t = 0; t < `CONV_TAPS; t++) wts[t] = weight_t'($random(seed) & 3);
		wts[4] = 8'sd127;
		program_frame(7, 5, 1'b1, 3, -24000);
		clamp_lo = 0;
		clamp_hi = 0;
		for (int r = 0; r < fr_h; r++) begin
			for (int c = 0; c < fr_w; c++) begin
				if (ref_pixel(r, c) == 8'h80) clamp_lo++;
				if (ref_pixel(r, c) == 8'h7f) clamp_hi++;
			end
		end
		if (clamp_lo == 0 || clamp_hi == 0) begin
			other_errors++;
			$display("Linear frame stimulus does not reach both clamp limits");
		end
		run_frame("linear 7x5");

		// Single column, then single row
		randomize_data(4);
		program_frame(1, 4, 1'b0, 1, 100);
		run_frame("1x4");
		randomize_data(4);
		program_frame(4, 1, 1'b0, 1, 100);
		run_frame("4x1");

		$display("Errors: %0d register or flag, %0d pixel, %0d other",
			value_errors, pixel_errors, other_errors);
		if (value_errors + pixel_errors + other_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog timeout after %0d cycles", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

endmodule

//--- conv_accel.f
+incdir+include
source/conv_pkg.sv
source/cfg_if.sv
source/bus_regs.sv
source/window_fetch.sv
source/mac_array.sv
source/act_quant.sv
source/conv_accel.sv
bench/tb_clock.sv
bench/tb_conv_accel.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the conv_accel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_conv_accel -f conv_accel.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_conv_accel > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
	echo "No pass message in sim.log"
	exit 1
fi
exit 0
